/* common/z80_params.svh */
`ifndef Z80_PARAMS_SVH
`define Z80_PARAMS_SVH

// ----------------------------------------------------------
// datapath widths
// ----------------------------------------------------------

// width of the internal data bus and of every 8-bit register
`define Z80_DATA_W 8
// width of the external address bus and of a register pair
`define Z80_ADDR_W 16
// half carry is taken across this bit boundary
`define Z80_NIB_W 4

// ----------------------------------------------------------
// flag register bit positions, bits 5 and 3 are unused
// ----------------------------------------------------------
`define Z80_FLAG_S  7
`define Z80_FLAG_Z  6
`define Z80_FLAG_H  4
`define Z80_FLAG_PV 2
`define Z80_FLAG_N  1
`define Z80_FLAG_C  0

`endif

/* common/z80_alu_pkg.sv */
`include "z80_params.svh"

package z80_alu_pkg;

  // one value on the data bus or in an 8-bit register
  typedef logic [`Z80_DATA_W-1:0] byte_t;

  // image of the flag register, bit positions come from the params header
  typedef logic [`Z80_DATA_W-1:0] flags_t;

  // 8-bit ALU operations
  // pass hands the bus operand through and leaves the flags alone
  typedef enum logic [3:0] {
    alu_pass = 4'd0,
    alu_add  = 4'd1,
    alu_adc  = 4'd2,
    alu_sub  = 4'd3,
    alu_sbc  = 4'd4,
    alu_and  = 4'd5,
    alu_or   = 4'd6,
    alu_xor  = 4'd7,
    alu_inc  = 4'd8
  } alu_op_t;

  // per flag override applied after the ALU flags are chosen
  typedef enum logic [1:0] {
    force_keep  = 2'b00,
    force_clear = 2'b10,
    force_set   = 2'b11
  } flag_force_t;

  // one override code for each of the six real flags
  typedef struct packed {
    flag_force_t s;
    flag_force_t z;
    flag_force_t h;
    flag_force_t pv;
    flag_force_t n;
    flag_force_t c;
  } flag_forces_t;

endpackage

/* common/z80_datapath_pkg.sv */
`include "z80_params.svh"

package z80_datapath_pkg;

  import z80_alu_pkg::*;

  // a full register pair as seen on the address bus
  typedef logic [`Z80_ADDR_W-1:0] addr_t;

  // byte registers of the register file, the order matches the storage index
  typedef enum logic [3:0] {
    reg_b   = 4'd0,
    reg_c   = 4'd1,
    reg_d   = 4'd2,
    reg_e   = 4'd3,
    reg_h   = 4'd4,
    reg_l   = 4'd5,
    reg_sph = 4'd6,
    reg_spl = 4'd7,
    reg_pch = 4'd8,
    reg_pcl = 4'd9
  } reg8_t;

  // register pairs that can drive the address bus
  typedef enum logic [2:0] {
    pair_bc = 3'd0,
    pair_de = 3'd1,
    pair_hl = 3'd2,
    pair_sp = 3'd3,
    pair_pc = 3'd4
  } pair_t;

  // who owns the internal data bus this cycle
  // anything but src_ext also drives the external data bus
  typedef enum logic [1:0] {
    src_ext   = 2'd0,
    src_reg   = 2'd1,
    src_acc   = 2'd2,
    src_flags = 2'd3
  } bus_src_t;

  // ----------------------------------------------------------
  // one micro-operation, a fresh word arrives every clock
  // ----------------------------------------------------------
  typedef struct packed {
    bus_src_t     data_src;      // internal data bus source
    reg8_t        reg_sel;       // byte register for both read and write
    logic         reg_ld;        // write the selected byte register
    logic         reg_from_alu;  // write the ALU result instead of the bus
    pair_t        pair_sel;      // pair shown on the address bus
    logic         addr_drive;    // drive the external address bus
    logic         acc_ld;        // load the accumulator
    logic         acc_from_alu;  // take the ALU result instead of the bus
    logic         flags_ld;      // load the ALU flags
    alu_op_t      alu_op;
    flag_forces_t forces;        // per flag set or clear on top of the flags
    logic         exx;           // swap BC, DE, HL with the shadow set
    logic         ex_af;         // swap AF with its shadow
  } ctrl_word_t;

endpackage

/* alu/z80_alu.sv */
`timescale 1ns/100ps
`include "z80_params.svh"

module z80_alu
  import z80_alu_pkg::*;
(
  input  byte_t   a,
  input  byte_t   b,
  input  alu_op_t op,
  input  flags_t  flags_in,
  output byte_t   result,
  output flags_t  flags_out
);

  // width of the low part and of the high part of the nibble split
  localparam int NIB = `Z80_NIB_W;
  localparam int DW  = `Z80_DATA_W;
  localparam int UPW = DW - NIB;

  logic           cin;
  logic           lo_c;
  logic           hi_c;
  logic [NIB-1:0] lo_res;
  logic [UPW-1:0] hi_res;

  // carry or borrow in, only the with-carry forms use the old C flag
  assign cin = ((op == alu_adc) || (op == alu_sbc)) && flags_in[`Z80_FLAG_C];

  always_comb begin
    result    = b;
    flags_out = flags_in;
    lo_c      = 1'b0;
    hi_c      = 1'b0;
    lo_res    = '0;
    hi_res    = '0;

    case (op)
      alu_add, alu_adc: begin
        // ripple across the nibble boundary so the half carry falls out
        {lo_c, lo_res} = {1'b0, a[NIB-1:0]} + {1'b0, b[NIB-1:0]} + (NIB+1)'(cin);
        {hi_c, hi_res} = {1'b0, a[DW-1:NIB]} + {1'b0, b[DW-1:NIB]} + (UPW+1)'(lo_c);
        result = {hi_res, lo_res};
        flags_out[`Z80_FLAG_H]  = lo_c;
        flags_out[`Z80_FLAG_C]  = hi_c;
        flags_out[`Z80_FLAG_N]  = 1'b0;
        // overflow when both operands share a sign that the result lacks
        flags_out[`Z80_FLAG_PV] = (a[DW-1] == b[DW-1]) && (result[DW-1] != a[DW-1]);
        flags_out[`Z80_FLAG_S]  = result[DW-1];
        flags_out[`Z80_FLAG_Z]  = (result == '0);
      end

      alu_sub, alu_sbc: begin
        // the extra top bit of each difference is the borrow out
        {lo_c, lo_res} = {1'b0, a[NIB-1:0]} - {1'b0, b[NIB-1:0]} - (NIB+1)'(cin);
        {hi_c, hi_res} = {1'b0, a[DW-1:NIB]} - {1'b0, b[DW-1:NIB]} - (UPW+1)'(lo_c);
        result = {hi_res, lo_res};
        flags_out[`Z80_FLAG_H]  = lo_c;
        flags_out[`Z80_FLAG_C]  = hi_c;
        flags_out[`Z80_FLAG_N]  = 1'b1;
        // overflow when the operand signs differ and the result sign flips from a
        flags_out[`Z80_FLAG_PV] = (a[DW-1] != b[DW-1]) && (result[DW-1] != a[DW-1]);
        flags_out[`Z80_FLAG_S]  = result[DW-1];
        flags_out[`Z80_FLAG_Z]  = (result == '0);
      end

      alu_and, alu_or, alu_xor: begin
        case (op)
          alu_and: result = a & b;
          alu_or:  result = a | b;
          default: result = a ^ b;
        endcase
        // only AND reports a half carry, all three clear N and C
        flags_out[`Z80_FLAG_H]  = (op == alu_and);
        flags_out[`Z80_FLAG_N]  = 1'b0;
        flags_out[`Z80_FLAG_C]  = 1'b0;
        // P/V is even parity here
        flags_out[`Z80_FLAG_PV] = ~^result;
        flags_out[`Z80_FLAG_S]  = result[DW-1];
        flags_out[`Z80_FLAG_Z]  = (result == '0);
      end

      alu_inc: begin
        // increments the bus operand so a register can count in place
        {lo_c, lo_res} = {1'b0, b[NIB-1:0]} + (NIB+1)'(1);
        {hi_c, hi_res} = {1'b0, b[DW-1:NIB]} + (UPW+1)'(lo_c);
        result = {hi_res, lo_res};
        flags_out[`Z80_FLAG_H]  = lo_c;
        flags_out[`Z80_FLAG_N]  = 1'b0;
        // only 7F rolling over to 80 overflows, C stays as it was
        flags_out[`Z80_FLAG_PV] = ~b[DW-1] & result[DW-1];
        flags_out[`Z80_FLAG_S]  = result[DW-1];
        flags_out[`Z80_FLAG_Z]  = (result == '0);
      end

      default: begin
        // pass and unused codes hand b through with the flags untouched
        result    = b;
        flags_out = flags_in;
      end
    endcase
  end

endmodule

/* regfile/z80_regfile.sv */
`timescale 1ns/100ps

module z80_regfile
  import z80_alu_pkg::*;
  import z80_datapath_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  reg8_t rd_sel,
  input  reg8_t wr_sel,
  input  logic  wr_en,
  input  byte_t wr_data,
  input  pair_t pair_sel,
  input  logic  exx,
  output byte_t rd_data,
  output addr_t pair_data
);

  // B, C, D, E, H, L, SPH, SPL, PCH, PCL in reg8_t order
  localparam int NUM_REGS = 10;
  // only the first six have a shadow copy
  localparam int NUM_SHADOW = 6;

  byte_t regs   [NUM_REGS];
  byte_t shadow [NUM_SHADOW];

  logic  rd_valid;
  logic  wr_valid;

  // reg8_t is four bits wide, codes past PCL select nothing
  assign rd_valid = (rd_sel <= reg_pcl);
  assign wr_valid = (wr_sel <= reg_pcl);

  // ----------------------------------------------------------
  // storage, byte writes and the exx exchange
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      for (int i = 0; i < NUM_SHADOW; i++) begin
        shadow[i] <= '0;
      end
    end else if (exx) begin
      // all six bytes trade places with their shadows in one edge
      for (int i = 0; i < NUM_SHADOW; i++) begin
        regs[i]   <= shadow[i];
        shadow[i] <= regs[i];
      end
    end else if (wr_en && wr_valid) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // ----------------------------------------------------------
  // read ports
  // ----------------------------------------------------------

  // byte port feeds the internal data bus mux in the top level
  assign rd_data = rd_valid ? regs[rd_sel] : '0;

  // pair port puts the high byte in the upper half of the address
  always_comb begin
    case (pair_sel)
      pair_bc: pair_data = {regs[reg_b], regs[reg_c]};
      pair_de: pair_data = {regs[reg_d], regs[reg_e]};
      pair_hl: pair_data = {regs[reg_h], regs[reg_l]};
      pair_sp: pair_data = {regs[reg_sph], regs[reg_spl]};
      pair_pc: pair_data = {regs[reg_pch], regs[reg_pcl]};
      default: pair_data = '0;
    endcase
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // the sequencer must never ask for a byte write during an exchange,
  // the write would be lost behind the swap
  a_exx_no_write: assert property (
    @(posedge clk) disable iff (reset)
    !(exx && wr_en)
  );

endmodule

/* design/z80_acc_flags.sv */
`timescale 1ns/100ps
`include "z80_params.svh"

module z80_acc_flags
  import z80_alu_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  byte_t        bus,
  input  byte_t        alu_result,
  input  flags_t       alu_flags,
  input  logic         acc_ld,
  input  logic         acc_from_alu,
  input  logic         flags_ld,
  input  flag_forces_t forces,
  input  logic         ex_af,
  output byte_t        acc,
  output flags_t       flags
);

  byte_t  acc_sh;
  flags_t flags_sh;
  flags_t base_flags;
  flags_t next_flags;
  logic   force_any;
  logic   flags_wr;

  // keep, clear or set one flag bit
  function automatic logic apply_force(input logic cur, input flag_force_t code);
    logic val;
    case (code)
      force_clear: val = 1'b0;
      force_set:   val = 1'b1;
      default:     val = cur;
    endcase
    return val;
  endfunction

  // ----------------------------------------------------------
  // flag rule
  // ----------------------------------------------------------
  assign force_any = (forces.s != force_keep) || (forces.z != force_keep) ||
                     (forces.h != force_keep) || (forces.pv != force_keep) ||
                     (forces.n != force_keep) || (forces.c != force_keep);

  // a lone force still writes the register, on top of the old flags
  assign flags_wr = flags_ld || force_any;

  always_comb begin
    base_flags = flags_ld ? alu_flags : flags;
    next_flags = base_flags;
    next_flags[`Z80_FLAG_S]  = apply_force(base_flags[`Z80_FLAG_S], forces.s);
    next_flags[`Z80_FLAG_Z]  = apply_force(base_flags[`Z80_FLAG_Z], forces.z);
    next_flags[`Z80_FLAG_H]  = apply_force(base_flags[`Z80_FLAG_H], forces.h);
    next_flags[`Z80_FLAG_PV] = apply_force(base_flags[`Z80_FLAG_PV], forces.pv);
    next_flags[`Z80_FLAG_N]  = apply_force(base_flags[`Z80_FLAG_N], forces.n);
    next_flags[`Z80_FLAG_C]  = apply_force(base_flags[`Z80_FLAG_C], forces.c);
  end

  // ----------------------------------------------------------
  // A, F and the shadow pair
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      acc      <= '0;
      acc_sh   <= '0;
      flags    <= '0;
      flags_sh <= '0;
    end else if (ex_af) begin
      // AF and AF' trade places as a whole
      acc      <= acc_sh;
      acc_sh   <= acc;
      flags    <= flags_sh;
      flags_sh <= flags;
    end else begin
      if (acc_ld) begin
        acc <= acc_from_alu ? alu_result : bus;
      end
      if (flags_wr) begin
        flags <= next_flags;
      end
    end
  end

  // an exchange cannot share the edge with a load of A or F
  a_ex_af_no_load: assert property (
    @(posedge clk) disable iff (reset)
    !(ex_af && (acc_ld || flags_ld))
  );

endmodule

/* design/z80_datapath.sv */
`timescale 1ns/100ps

module z80_datapath
  import z80_alu_pkg::*;
  import z80_datapath_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ctrl_word_t ctrl,
  input  byte_t      data_in,
  output byte_t      data_out,
  output logic       data_drive,
  output addr_t      addr_out,
  output logic       addr_drive,
  output flags_t     flags
);

  byte_t  bus;
  byte_t  reg_rd;
  byte_t  reg_wr_data;
  addr_t  pair_data;
  byte_t  acc;
  byte_t  alu_result;
  flags_t alu_flags;

  // ----------------------------------------------------------
  // internal data bus
  // ----------------------------------------------------------

  // exactly one source owns the bus, the outside world by default
  always_comb begin
    case (ctrl.data_src)
      src_reg:   bus = reg_rd;
      src_acc:   bus = acc;
      src_flags: bus = flags;
      default:   bus = data_in;
    endcase
  end

  // the ALU result reaches the register file on its own path, so an
  // INC can read a register over the bus and write it back in one cycle
  assign reg_wr_data = ctrl.reg_from_alu ? alu_result : bus;

  // ----------------------------------------------------------
  // external bus outputs
  // ----------------------------------------------------------
  assign data_drive = (ctrl.data_src != src_ext);
  assign data_out   = data_drive ? bus : '0;
  assign addr_drive = ctrl.addr_drive;
  assign addr_out   = addr_drive ? pair_data : '0;

  // ----------------------------------------------------------
  // blocks
  // ----------------------------------------------------------

  // one select serves read and write, the same byte is read and written back
  z80_regfile i_regfile (
    .clk       (clk),
    .reset     (reset),
    .rd_sel    (ctrl.reg_sel),
    .wr_sel    (ctrl.reg_sel),
    .wr_en     (ctrl.reg_ld),
    .wr_data   (reg_wr_data),
    .pair_sel  (ctrl.pair_sel),
    .exx       (ctrl.exx),
    .rd_data   (reg_rd),
    .pair_data (pair_data)
  );

  z80_acc_flags i_acc_flags (
    .clk          (clk),
    .reset        (reset),
    .bus          (bus),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .acc_ld       (ctrl.acc_ld),
    .acc_from_alu (ctrl.acc_from_alu),
    .flags_ld     (ctrl.flags_ld),
    .forces       (ctrl.forces),
    .ex_af        (ctrl.ex_af),
    .acc          (acc),
    .flags        (flags)
  );

  // A operand is always the accumulator, B operand is whatever is on the bus
  z80_alu i_alu (
    .a         (acc),
    .b         (bus),
    .op        (ctrl.alu_op),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

endmodule

/* testbench/z80_datapath_tb_cases.svh */
`ifndef Z80_DATAPATH_TB_CASES_SVH
`define Z80_DATAPATH_TB_CASES_SVH

// fills the table, every row gets its expected values from the model
task automatic build_table();
  ctrl_word_t c;
  // 1: every byte register written from data_in and read back over the bus
  for (int r = 0; r < 10; r++) load_reg(1, r, rand_byte());
  for (int r = 0; r < 10; r++) read_reg(1, r);

  // 2: both halves of a pair, then the pair on the address bus
  for (int p = 0; p < 5; p++) begin
    load_reg(2, 2 * p, rand_byte());
    load_reg(2, 2 * p + 1, rand_byte());
    c = idle_ctrl();
    c.pair_sel   = pair_t'(p);
    c.addr_drive = 1'b1;
    add_step(2, c, 8'h00);
  end

  // 3: two rounds of every ALU op into A, with A read back after each
  c = idle_ctrl();
  c.acc_ld = 1'b1;
  add_step(3, c, rand_byte());
  for (int round = 0; round < 2; round++) begin
    for (int k = 0; k < 9; k++) begin
      c = idle_ctrl();
      c.alu_op       = alu_ops[k];
      c.acc_ld       = 1'b1;
      c.acc_from_alu = 1'b1;
      c.flags_ld     = 1'b1;
      add_step(3, c, rand_byte());
      read_src(3, src_acc);
    end
  end

  // 4: INC of D across the sign boundary and the wrap, C must survive
  load_reg(4, 2, 8'h7F);
  force_step(4, 5, force_set, 1'b0);
  inc_reg(4, 2);
  read_reg(4, 2);
  load_reg(4, 2, 8'hFF);
  force_step(4, 5, force_clear, 1'b0);
  inc_reg(4, 2);
  read_reg(4, 2);

  // 5: each force code on its own and on top of a flag load
  for (int f = 0; f < 6; f++) begin
    force_step(5, f, force_set, 1'b0);
    force_step(5, f, force_clear, 1'b1);
    force_step(5, f, force_set, 1'b1);
    force_step(5, f, force_clear, 1'b0);
  end

  // 6: exx twice and three times, then the same for AF
  for (int r = 0; r < 6; r++) load_reg(6, r, rand_byte());
  c = idle_ctrl();
  c.exx = 1'b1;
  add_step(6, c, 8'h00);
  for (int r = 0; r < 6; r++) load_reg(6, r, rand_byte());
  for (int n = 0; n < 3; n++) begin
    add_step(6, c, 8'h00);
    for (int r = 0; r < 6; r++) read_reg(6, r);
  end
  c = idle_ctrl();
  c.acc_ld = 1'b1;
  add_step(6, c, rand_byte());
  force_step(6, 1, force_set, 1'b0);
  c = idle_ctrl();
  c.ex_af = 1'b1;
  add_step(6, c, 8'h00);
  c = idle_ctrl();
  c.acc_ld       = 1'b1;
  c.acc_from_alu = 1'b1;
  c.flags_ld     = 1'b1;
  c.alu_op       = alu_add;
  add_step(6, c, rand_byte());
  for (int n = 0; n < 2; n++) begin
    c = idle_ctrl();
    c.ex_af = 1'b1;
    add_step(6, c, 8'h00);
    read_src(6, src_acc);
    read_src(6, src_flags);
  end
endtask

`endif

/* testbench/z80_datapath_tb.sv */
`timescale 1ns/100ps
`include "z80_params.svh"

module z80_datapath_tb
  import z80_alu_pkg::*;
  import z80_datapath_pkg::*;
();

  // one row of the table: the stimulus for a cycle and what the DUT must show
  typedef struct {
    int         test_id;
    ctrl_word_t ctrl;
    byte_t      din;
    byte_t      exp_dout;
    logic       exp_drive;
    addr_t      exp_addr;
    flags_t     exp_flags;
  } step_t;

  logic       clk;
  logic       reset;
  ctrl_word_t ctrl;
  byte_t      data_in;
  byte_t      data_out;
  logic       data_drive;
  addr_t      addr_out;
  logic       addr_drive;
  flags_t     flags;

  step_t      table_q[$];
  logic       table_ready;
  logic [15:0] lfsr;
  int         errors;
  int         checks;

  // reference state, updated as each row is added to the table
  byte_t      m_regs [10];
  byte_t      m_shadow [6];
  byte_t      m_acc;
  byte_t      m_acc_sh;
  flags_t     m_flags;
  flags_t     m_flags_sh;

  alu_op_t    alu_ops [9] = '{alu_add, alu_adc, alu_sub, alu_sbc, alu_and,
                              alu_or, alu_xor, alu_inc, alu_pass};
  string      test_names [7] = '{"", "register load and read", "pair on address bus",
                                 "accumulator ALU ops", "register INC", "flag forces",
                                 "shadow exchanges"};

  z80_datapath i_dut (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_drive (data_drive),
    .addr_out   (addr_out),
    .addr_drive (addr_drive),
    .flags      (flags)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------
  // random operands
  // ----------------------------------------------------------

  // one step of a 16-bit Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // every bit of the byte costs one LFSR step
  function automatic byte_t rand_byte();
    byte_t v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  // flags follow the Z80 rules with plain integer arithmetic
  function automatic void model_alu(input byte_t a, input byte_t b, input alu_op_t op,
                                    input flags_t fin, output byte_t res,
                                    output flags_t fo);
    int cin;
    int wide;
    int sgn;
    fo  = fin;
    res = b;
    cin = (((op == alu_adc) || (op == alu_sbc)) && fin[`Z80_FLAG_C]) ? 1 : 0;
    case (op)
      alu_add, alu_adc: begin
        wide = int'(a) + int'(b) + cin;
        sgn  = int'($signed(a)) + int'($signed(b)) + cin;
        res  = byte_t'(wide);
        fo[`Z80_FLAG_H]  = (int'(a[3:0]) + int'(b[3:0]) + cin) > 15;
        fo[`Z80_FLAG_C]  = wide > 255;
        fo[`Z80_FLAG_PV] = (sgn > 127) || (sgn < -128);
        fo[`Z80_FLAG_N]  = 1'b0;
      end
      alu_sub, alu_sbc: begin
        wide = int'(a) - int'(b) - cin;
        sgn  = int'($signed(a)) - int'($signed(b)) - cin;
        res  = byte_t'(wide);
        fo[`Z80_FLAG_H]  = (int'(a[3:0]) - int'(b[3:0]) - cin) < 0;
        fo[`Z80_FLAG_C]  = wide < 0;
        fo[`Z80_FLAG_PV] = (sgn > 127) || (sgn < -128);
        fo[`Z80_FLAG_N]  = 1'b1;
      end
      alu_and, alu_or, alu_xor: begin
        if (op == alu_and) res = a & b;
        else if (op == alu_or) res = a | b;
        else res = a ^ b;
        fo[`Z80_FLAG_H]  = (op == alu_and);
        fo[`Z80_FLAG_N]  = 1'b0;
        fo[`Z80_FLAG_C]  = 1'b0;
        // even parity sets P/V
        fo[`Z80_FLAG_PV] = ($countones(res) % 2) == 0;
      end
      alu_inc: begin
        res = b + 8'd1;
        fo[`Z80_FLAG_H]  = (b[3:0] == 4'hF);
        fo[`Z80_FLAG_PV] = (b == 8'h7F);
        fo[`Z80_FLAG_N]  = 1'b0;
      end
      default: ;
    endcase
    if (op != alu_pass) begin
      fo[`Z80_FLAG_S] = res[7];
      fo[`Z80_FLAG_Z] = (res == 8'h00);
    end
  endfunction

  function automatic byte_t model_bus(input ctrl_word_t c, input byte_t din);
    case (c.data_src)
      src_reg:   return (int'(c.reg_sel) < 10) ? m_regs[c.reg_sel] : 8'h00;
      src_acc:   return m_acc;
      src_flags: return m_flags;
      default:   return din;
    endcase
  endfunction

  // pairs sit on consecutive byte registers, high byte first
  function automatic addr_t model_pair(input pair_t p);
    if (int'(p) > 4) return '0;
    return {m_regs[2 * int'(p)], m_regs[2 * int'(p) + 1]};
  endfunction

  function automatic ctrl_word_t idle_ctrl();
    return '0;
  endfunction

  // runs one cycle through the model and appends the row with its expectations
  task automatic add_step(input int test_id, input ctrl_word_t c, input byte_t din);
    step_t        s;
    byte_t        bus;
    byte_t        res;
    byte_t        tmp;
    flags_t       af;
    flags_t       nf;
    int           pos [6];
    flag_force_t  codes [6];
    pos   = '{`Z80_FLAG_S, `Z80_FLAG_Z, `Z80_FLAG_H, `Z80_FLAG_PV, `Z80_FLAG_N, `Z80_FLAG_C};
    codes = '{c.forces.s, c.forces.z, c.forces.h, c.forces.pv, c.forces.n, c.forces.c};
    bus = model_bus(c, din);
    model_alu(m_acc, bus, c.alu_op, m_flags, res, af);
    if (c.exx) begin
      for (int i = 0; i < 6; i++) begin
        tmp         = m_regs[i];
        m_regs[i]   = m_shadow[i];
        m_shadow[i] = tmp;
      end
    end else if (c.reg_ld && int'(c.reg_sel) < 10) begin
      m_regs[c.reg_sel] = c.reg_from_alu ? res : bus;
    end
    if (c.ex_af) begin
      tmp        = m_acc;
      m_acc      = m_acc_sh;
      m_acc_sh   = tmp;
      nf         = m_flags;
      m_flags    = m_flags_sh;
      m_flags_sh = nf;
    end else begin
      if (c.acc_ld) m_acc = c.acc_from_alu ? res : bus;
      nf = c.flags_ld ? af : m_flags;
      for (int i = 0; i < 6; i++) begin
        if (codes[i] == force_set) nf[pos[i]] = 1'b1;
        else if (codes[i] == force_clear) nf[pos[i]] = 1'b0;
      end
      if (c.flags_ld || c.forces != '0) m_flags = nf;
    end
    // outputs are sampled after the edge, so they show the new state
    s.test_id   = test_id;
    s.ctrl      = c;
    s.din       = din;
    s.exp_drive = (c.data_src != src_ext);
    s.exp_dout  = s.exp_drive ? model_bus(c, din) : 8'h00;
    s.exp_addr  = c.addr_drive ? model_pair(c.pair_sel) : '0;
    s.exp_flags = m_flags;
    table_q.push_back(s);
  endtask

  // ----------------------------------------------------------
  // row helpers used by the table
  // ----------------------------------------------------------
  task automatic load_reg(input int t, input int r, input byte_t v);
    ctrl_word_t c;
    c = idle_ctrl();
    c.reg_sel = reg8_t'(r);
    c.reg_ld  = 1'b1;
    add_step(t, c, v);
  endtask

  task automatic read_reg(input int t, input int r);
    ctrl_word_t c;
    c = idle_ctrl();
    c.data_src = src_reg;
    c.reg_sel  = reg8_t'(r);
    add_step(t, c, 8'h00);
  endtask

  task automatic read_src(input int t, input bus_src_t src);
    ctrl_word_t c;
    c = idle_ctrl();
    c.data_src = src;
    add_step(t, c, 8'h00);
  endtask

  // count a register in place through the ALU
  task automatic inc_reg(input int t, input int r);
    ctrl_word_t c;
    c = idle_ctrl();
    c.data_src     = src_reg;
    c.reg_sel      = reg8_t'(r);
    c.reg_ld       = 1'b1;
    c.reg_from_alu = 1'b1;
    c.alu_op       = alu_inc;
    c.flags_ld     = 1'b1;
    add_step(t, c, 8'h00);
  endtask

  // idx counts S, Z, H, P/V, N, C from 0 to 5
  task automatic force_step(input int t, input int idx, input flag_force_t code,
                            input logic with_ld);
    ctrl_word_t c;
    c = idle_ctrl();
    c.data_src = src_flags;
    case (idx)
      0: c.forces.s = code;
      1: c.forces.z = code;
      2: c.forces.h = code;
      3: c.forces.pv = code;
      4: c.forces.n = code;
      default: c.forces.c = code;
    endcase
    if (with_ld) begin
      c.flags_ld = 1'b1;
      c.alu_op   = alu_xor;
    end
    add_step(t, c, 8'h00);
  endtask

  `include "z80_datapath_tb_cases.svh"

  // ----------------------------------------------------------
  // watchdog, twenty clocks per row
  // ----------------------------------------------------------
  initial begin
    wait (table_ready);
    #(table_q.size() * 20 * 10);
    $display("watchdog expired before the table finished");
    $display("Test FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // stimulus and checks
  // ----------------------------------------------------------
  initial begin
    int    test_err;
    int    test_steps;
    step_t s;
    clk         = 1'b0;
    reset       = 1'b1;
    ctrl        = idle_ctrl();
    data_in     = 8'h00;
    lfsr        = 16'd23;
    errors      = 0;
    checks      = 0;
    test_err    = 0;
    test_steps  = 0;
    table_ready = 1'b0;
    for (int i = 0; i < 10; i++) m_regs[i] = 8'h00;
    for (int i = 0; i < 6; i++) m_shadow[i] = 8'h00;
    m_acc      = 8'h00;
    m_acc_sh   = 8'h00;
    m_flags    = 8'h00;
    m_flags_sh = 8'h00;
    build_table();
    table_ready = 1'b1;

    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < table_q.size(); i++) begin
      s = table_q[i];
      @(negedge clk);
      ctrl    = s.ctrl;
      data_in = s.din;
      // sample one ns before the next falling edge
      @(posedge clk);
      #4;
      checks += 3;
      test_steps++;
      assert (data_out === s.exp_dout && data_drive === s.exp_drive) else begin
        $display("[ERROR] %0t: step %0d data_out %h drive %b, expected %h drive %b",
                 $time, i, data_out, data_drive, s.exp_dout, s.exp_drive);
        errors++;
        test_err++;
      end
      assert (addr_out === s.exp_addr && addr_drive === s.ctrl.addr_drive) else begin
        $display("[ERROR] %0t: step %0d addr_out %h, expected %h",
                 $time, i, addr_out, s.exp_addr);
        errors++;
        test_err++;
      end
      assert (flags === s.exp_flags) else begin
        $display("[ERROR] %0t: step %0d flags %b, expected %b",
                 $time, i, flags, s.exp_flags);
        errors++;
        test_err++;
      end
      if (i == table_q.size() - 1 || table_q[i + 1].test_id != s.test_id) begin
        $display("test %0d %s: %0d steps, %0d errors",
                 s.test_id, test_names[s.test_id], test_steps, test_err);
        test_err   = 0;
        test_steps = 0;
      end
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+common
+incdir+testbench
common/z80_alu_pkg.sv
common/z80_datapath_pkg.sv
alu/z80_alu.sv
regfile/z80_regfile.sv
design/z80_acc_flags.sv
design/z80_datapath.sv
testbench/z80_datapath_tb.sv

/* Makefile */
# Verilator build and run of the datapath testbench

VERILATOR ?= verilator
TOP       ?= z80_datapath_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard common/*.sv common/*.svh alu/*.sv regfile/*.sv \
          design/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the testbench printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)
